// File: interboard_receiver.f
logic/link_pkg.sv
logic/link_handshake.sv
logic/message_assembler.sv
logic/message_queue.sv
logic/interboard_receiver.sv
testbench/interboard_receiver_asserts.sv
testbench/interboard_receiver_tb.sv

// File: Makefile
# Verilator build and run for the interboard receiver

VERILATOR ?= verilator
TOP       ?= interboard_receiver_tb
FILELIST  ?= interboard_receiver.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(wildcard logic/*.sv testbench/*.sv) testbench/link_input.txt
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "test: pass line found in $(LOG)"; \
	else \
		echo "test: pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/link_input.txt
// kind_type_x_y_card_len_last in hex, kind 1 message, 2 abort, 3 hold reading
// last digit is the move direction, the field count before an abort, or the held message count
1_3_0a_5_21_2_1  // single message
1_1_00_0_00_0_0
1_f_1f_7_3e_7_1
1_2_11_2_07_1_0
1_4_05_6_2a_3_1
1_0_1e_3_3e_5_0
2_6_0c_4_11_0_2  // abort after two fields
1_7_14_1_30_6_1
3_0_00_0_00_0_3  // hold reading for three messages
1_8_03_2_12_4_0
1_9_16_5_2c_1_1
2_a_09_7_05_2_4  // abort inside the held burst
1_b_1b_0_0f_7_1
3_0_00_0_00_0_5  // five messages, the last one is dropped
1_c_01_1_01_1_0
1_d_02_2_02_2_1
1_e_03_3_03_3_0
1_5_04_4_04_4_1
1_6_05_5_05_5_0
1_7_1d_6_3d_0_1  // received after overflow

// File: testbench/interboard_receiver_tb.sv
`timescale 1ns/10ps

module interboard_receiver_tb;

    localparam int    CLK_PERIOD = 100;
    localparam int    MAX_CMDS   = 64;
    localparam int    DRAIN_MAX  = 200;
    localparam string INPUT_FILE = "testbench/link_input.txt";

    // kind, type, x, y, card, len, last digit
    typedef logic [35:0] cmd_t;

    logic                clk;
    logic                rst_n;
    logic                request;
    link_pkg::symbol_t   link_data;
    logic                ack;
    logic                link_abort;
    logic                msg_valid;
    logic                msg_pop;
    link_pkg::msg_type_t msg_type;
    link_pkg::block_x_t  block_x;
    link_pkg::block_y_t  block_y;
    link_pkg::card_t     card;
    link_pkg::sel_len_t  sel_len;
    link_pkg::move_dir_t move_dir;
    logic                overflow;

    cmd_t   cmds [MAX_CMDS];
    cmd_t   exp_q [$];   // oldest expected message first
    int     num_cmds;
    int     held;
    int     hold_left;
    int     value_errors;
    int     protocol_errors;
    integer seed;
    logic   reader_hold;
    logic   exp_overflow;
    logic   loaded;

    interboard_receiver DUT (
        .clk(clk), .rst_n(rst_n), .request(request), .link_data(link_data), .ack(ack),
        .link_abort(link_abort), .msg_valid(msg_valid), .msg_pop(msg_pop),
        .msg_type(msg_type), .block_x(block_x), .block_y(block_y), .card(card),
        .sel_len(sel_len), .move_dir(move_dir), .overflow(overflow)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // symbol for field f of a command word, in link order
    function automatic link_pkg::symbol_t field_symbol(input cmd_t w, input int f);
        case (f)
            0:       return link_pkg::symbol_t'(w[31:28]);
            1:       return link_pkg::symbol_t'(w[24:20]);
            2:       return link_pkg::symbol_t'(w[18:16]);
            3:       return link_pkg::symbol_t'(w[13:8]);
            4:       return link_pkg::symbol_t'(w[6:4]);
            default: return link_pkg::symbol_t'(w[0]);
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        value_errors++;
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    endtask

    task automatic check_type(input link_pkg::msg_type_t exp, input link_pkg::msg_type_t act);
        if (act !== exp) begin
            report_mismatch("msg_type", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_x(input link_pkg::block_x_t exp, input link_pkg::block_x_t act);
        if (act !== exp) begin
            report_mismatch("block_x", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_y(input link_pkg::block_y_t exp, input link_pkg::block_y_t act);
        if (act !== exp) begin
            report_mismatch("block_y", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_card(input link_pkg::card_t exp, input link_pkg::card_t act);
        if (act !== exp) begin
            report_mismatch("card", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_len(input link_pkg::sel_len_t exp, input link_pkg::sel_len_t act);
        if (act !== exp) begin
            report_mismatch("sel_len", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_dir(input link_pkg::move_dir_t exp, input link_pkg::move_dir_t act);
        if (act !== exp) begin
            report_mismatch("move_dir", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch(name, 32'(exp), 32'(act));
        end
    endtask

    task automatic check_ack_len(input int width);
        if (width != link_pkg::ACK_LEN + 1) begin
            report_mismatch("ack window", 32'(link_pkg::ACK_LEN + 1), 32'(width));
        end
    endtask

    task automatic check_message(input cmd_t w);
        check_type(link_pkg::msg_type_t'(field_symbol(w, 0)), msg_type);
        check_x(link_pkg::block_x_t'(field_symbol(w, 1)), block_x);
        check_y(link_pkg::block_y_t'(field_symbol(w, 2)), block_y);
        check_card(link_pkg::card_t'(field_symbol(w, 3)), card);
        check_len(link_pkg::sel_len_t'(field_symbol(w, 4)), sel_len);
        check_dir(link_pkg::move_dir_t'(field_symbol(w, 5)), move_dir);
        check_flag("overflow", exp_overflow, overflow);
    endtask

    task automatic send_symbol(input link_pkg::symbol_t sym);
        int wait_cycles;
        int width;
        wait_cycles = 0;
        width = 0;
        request = 1'b1;
        link_data = sym;
        while (!ack && wait_cycles < 4) begin
            @(posedge clk);
            #5;
            wait_cycles++;
        end
        request = 1'b0;   // data stays until ack falls
        if (!ack) begin
            protocol_errors++;
            $display("ERROR at %0t: symbol %0h was never acknowledged", $time, sym);
        end else begin
            while (ack && width < link_pkg::ACK_LEN + 4) begin
                width++;
                @(posedge clk);
                #5;
            end
            check_ack_len(width);
        end
    endtask

    task automatic send_abort;
        request = 1'b1;
        link_data = link_pkg::ABORT_CODE;
        @(posedge clk);
        #5;
        check_flag("link_abort", 1'b1, link_abort);
        check_flag("ack", 1'b0, ack);
        @(posedge clk);
        #5;
        check_flag("link_abort", 1'b0, link_abort);   // code still held, no second pulse
        check_flag("ack", 1'b0, ack);
        request = 1'b0;
        link_data = '0;
        @(posedge clk);
        #5;
        check_flag("link_abort", 1'b0, link_abort);
    endtask

    task automatic wait_drained;
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || msg_valid) && cycles < DRAIN_MAX) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (exp_q.size() != 0 || msg_valid) begin
            protocol_errors++;
            $display("ERROR at %0t: queue did not drain, %0d messages still expected",
                     $time, exp_q.size());
        end
    endtask

    task automatic send_message(input cmd_t w);
        for (int f = 0; f < 6; f++) begin
            send_symbol(field_symbol(w, f));
        end
        if (!reader_hold) begin
            exp_q.push_back(w);
        end else if (held < link_pkg::QUEUE_DEPTH) begin
            exp_q.push_back(w);
            held++;
        end else begin
            exp_overflow = 1'b1;   // full queue drops it
        end
        if (reader_hold) begin
            hold_left--;
            if (hold_left == 0) begin
                repeat (2) begin
                    @(posedge clk);
                    #5;
                end
                check_flag("overflow", exp_overflow, overflow);
                reader_hold = 1'b0;
                wait_drained();
            end
        end
    endtask

    task automatic print_counts;
        $display("errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
    endtask

    initial begin : pop_loop
        int   delay;
        cmd_t head;
        msg_pop = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            if (msg_valid === 1'b1 && !reader_hold) begin
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) begin
                    @(posedge clk);
                    #5;
                end
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("ERROR at %0t: message received with none expected", $time);
                end else begin
                    head = exp_q.pop_front();
                    check_message(head);
                end
                msg_pop = 1'b1;
                @(posedge clk);
                #5;
                msg_pop = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded === 1'b1);
        limit = num_cmds * 6 * 2 * (link_pkg::ACK_LEN + 2) + 500;
        repeat (limit) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, run stopped", limit);
        print_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        clk = 1'b0;
        rst_n = 1'b0;
        request = 1'b0;
        link_data = '0;
        seed = 32'h5bca85cc;
        reader_hold = 1'b0;
        exp_overflow = 1'b0;
        value_errors = 0;
        protocol_errors = 0;
        held = 0;
        hold_left = 0;
        loaded = 1'b0;
        for (int i = 0; i < MAX_CMDS; i++) begin
            cmds[i] = '0;
        end
        $readmemh(INPUT_FILE, cmds);
        num_cmds = 0;
        while (num_cmds < MAX_CMDS && cmds[num_cmds][35:32] != 4'h0) begin
            num_cmds++;
        end
        if (num_cmds == 0) begin
            protocol_errors++;
            $display("ERROR: no commands found in %s", INPUT_FILE);
        end
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        #5;
        check_flag("ack", 1'b0, ack);
        check_flag("link_abort", 1'b0, link_abort);
        check_flag("msg_valid", 1'b0, msg_valid);
        check_flag("overflow", 1'b0, overflow);
        rst_n = 1'b1;

        for (int i = 0; i < num_cmds; i++) begin
            case (cmds[i][35:32])
                4'h1: begin
                    send_message(cmds[i]);
                end
                4'h2: begin
                    for (int f = 0; f < int'(cmds[i][3:0]); f++) begin
                        send_symbol(field_symbol(cmds[i], f));
                    end
                    send_abort();
                end
                4'h3: begin
                    wait_drained();
                    held = 0;
                    hold_left = int'(cmds[i][3:0]);
                    reader_hold = 1'b1;
                end
                default: begin
                    protocol_errors++;
                    $display("ERROR: unknown command %0h on line %0d", cmds[i], i);
                end
            endcase
        end

        wait_drained();
        check_flag("overflow", exp_overflow, overflow);
        check_flag("ack", 1'b0, ack);
        print_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/interboard_receiver_asserts.sv
`timescale 1ns/10ps

module interboard_receiver_asserts (
    input logic clk,
    input logic rst_n,
    input logic ack,
    input logic sym_done,
    input logic msg_valid,
    input logic msg_push,
    input logic msg_pop,
    input logic overflow
);

    int ack_run;   // cycles of ack high so far
    int occ;       // occupancy from pushes and pops alone

    always_ff @(posedge clk) begin
        if (!rst_n || !ack) begin
            ack_run <= 0;
        end else begin
            ack_run <= ack_run + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ <= 0;
        end else begin
            occ <= occ + ((msg_push && occ < link_pkg::QUEUE_DEPTH) ? 1 : 0)
                       - ((msg_pop && occ > 0) ? 1 : 0);
        end
    end

    ack_len_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> (ack_run == link_pkg::ACK_LEN + 1))
        else $error("ack window lasted %0d cycles", ack_run);

    done_in_ack_a: assert property (@(posedge clk) disable iff (!rst_n)
        sym_done |-> (ack && ack_run == link_pkg::ACK_LEN))
        else $error("sym_done outside the last ack cycle");

    valid_not_empty_a: assert property (@(posedge clk) disable iff (!rst_n)
        msg_valid |-> (occ != 0))
        else $error("msg_valid with an empty queue");

    overflow_sticky_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(overflow) |-> $past(!rst_n))
        else $error("overflow cleared without reset");

endmodule

bind link_handshake interboard_receiver_asserts hs_chk (
    .clk(clk), .rst_n(rst_n), .ack(ack), .sym_done(sym_done), .msg_valid(1'b0),
    .msg_push(1'b0), .msg_pop(1'b0), .overflow(1'b0)
);

bind message_queue interboard_receiver_asserts queue_chk (
    .clk(clk), .rst_n(rst_n), .ack(1'b0), .sym_done(1'b0), .msg_valid(msg_valid),
    .msg_push(msg_push), .msg_pop(msg_pop), .overflow(overflow)
);

// File: logic/interboard_receiver.sv
`timescale 1ns/10ps

module interboard_receiver (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                request,
    input  link_pkg::symbol_t   link_data,
    output logic                ack,
    output logic                link_abort,
    output logic                msg_valid,
    input  logic                msg_pop,
    output link_pkg::msg_type_t msg_type,
    output link_pkg::block_x_t  block_x,
    output link_pkg::block_y_t  block_y,
    output link_pkg::card_t     card,
    output link_pkg::sel_len_t  sel_len,
    output link_pkg::move_dir_t move_dir,
    output logic                overflow
);

    logic                sym_done;
    link_pkg::symbol_t   sym_data;
    logic                msg_push;
    link_pkg::msg_word_t msg_word;

    link_handshake u_handshake (
        .clk        (clk),
        .rst_n      (rst_n),
        .request    (request),
        .link_data  (link_data),
        .ack        (ack),
        .sym_done   (sym_done),
        .sym_data   (sym_data),
        .link_abort (link_abort)
    );

    message_assembler u_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .sym_done   (sym_done),
        .sym_data   (sym_data),
        .link_abort (link_abort),
        .msg_push   (msg_push),
        .msg_word   (msg_word)
    );

    // abort never reaches the queue, stored messages survive
    message_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .msg_push   (msg_push),
        .msg_word   (msg_word),
        .msg_pop    (msg_pop),
        .msg_valid  (msg_valid),
        .msg_type   (msg_type),
        .block_x    (block_x),
        .block_y    (block_y),
        .card       (card),
        .sel_len    (sel_len),
        .move_dir   (move_dir),
        .overflow   (overflow)
    );

endmodule

// File: logic/message_queue.sv
`timescale 1ns/10ps

module message_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                msg_push,
    input  link_pkg::msg_word_t msg_word,
    input  logic                msg_pop,
    output logic                msg_valid,
    output link_pkg::msg_type_t msg_type,
    output link_pkg::block_x_t  block_x,
    output link_pkg::block_y_t  block_y,
    output link_pkg::card_t     card,
    output link_pkg::sel_len_t  sel_len,
    output link_pkg::move_dir_t move_dir,
    output logic                overflow
);

    link_pkg::msg_word_t mem [link_pkg::QUEUE_DEPTH];
    link_pkg::qptr_t     wr_ptr;
    link_pkg::qptr_t     rd_ptr;
    link_pkg::qcount_t   count;
    logic                full;
    logic                push_ok;
    logic                pop_ok;

    assign full      = (count == link_pkg::Q_FULL);
    assign msg_valid = (count != '0);
    assign push_ok   = msg_push && !full;    // link cannot stall, so drop
    assign pop_ok    = msg_pop && msg_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + link_pkg::qptr_t'(1);
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + link_pkg::qptr_t'(1);
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + link_pkg::qcount_t'(1);
                2'b01:   count <= count - link_pkg::qcount_t'(1);
                default: count <= count;   // both or neither
            endcase
            if (msg_push && full) begin
                overflow <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= msg_word;
        end
    end

    // head entry, same packing as the assembler
    assign {msg_type, block_x, block_y, card, sel_len, move_dir} = mem[rd_ptr];

endmodule

// File: logic/message_assembler.sv
`timescale 1ns/10ps

module message_assembler (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sym_done,
    input  link_pkg::symbol_t   sym_data,
    input  logic                link_abort,
    output logic                msg_push,
    output link_pkg::msg_word_t msg_word
);

    link_pkg::asm_state_t state;
    link_pkg::asm_state_t state_next;

    link_pkg::msg_type_t msg_type;
    link_pkg::block_x_t  block_x;
    link_pkg::block_y_t  block_y;
    link_pkg::card_t     card;
    link_pkg::sel_len_t  sel_len;
    link_pkg::move_dir_t move_dir;

    always_comb begin
        state_next = state;
        case (state)
            link_pkg::get_type: if (sym_done) state_next = link_pkg::get_x;
            link_pkg::get_x:    if (sym_done) state_next = link_pkg::get_y;
            link_pkg::get_y:    if (sym_done) state_next = link_pkg::get_card;
            link_pkg::get_card: if (sym_done) state_next = link_pkg::get_len;
            link_pkg::get_len:  if (sym_done) state_next = link_pkg::get_dir;
            link_pkg::get_dir:  if (sym_done) state_next = link_pkg::finish;
            link_pkg::finish:   state_next = link_pkg::get_type;
            default:            state_next = link_pkg::get_type;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= link_pkg::get_type;
        end else if (link_abort) begin
            state <= link_pkg::get_type;   // partial message dropped
        end else begin
            state <= state_next;
        end
    end

    // field capture, low bits of each symbol
    always_ff @(posedge clk) begin
        if (link_abort) begin
            msg_type <= '0;
            block_x  <= '0;
            block_y  <= '0;
            card     <= '0;
            sel_len  <= '0;
            move_dir <= '0;
        end else if (sym_done) begin
            case (state)
                link_pkg::get_type: msg_type <= sym_data[$bits(link_pkg::msg_type_t)-1:0];
                link_pkg::get_x:    block_x  <= sym_data[$bits(link_pkg::block_x_t)-1:0];
                link_pkg::get_y:    block_y  <= sym_data[$bits(link_pkg::block_y_t)-1:0];
                link_pkg::get_card: card     <= sym_data[$bits(link_pkg::card_t)-1:0];
                link_pkg::get_len:  sel_len  <= sym_data[$bits(link_pkg::sel_len_t)-1:0];
                link_pkg::get_dir:  move_dir <= sym_data[0];
                default: begin
                end
            endcase
        end
    end

    assign msg_push = (state == link_pkg::finish);
    assign msg_word = {msg_type, block_x, block_y, card, sel_len, move_dir};

endmodule

// File: logic/link_handshake.sv
`timescale 1ns/10ps

module link_handshake (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              request,
    input  link_pkg::symbol_t link_data,
    output logic              ack,
    output logic              sym_done,
    output link_pkg::symbol_t sym_data,
    output logic              link_abort
);

    link_pkg::hs_state_t state;
    link_pkg::ack_cnt_t  ack_cnt;
    logic                abort_now;
    logic                abort_q;   // abort code seen last cycle

    assign abort_now = request && (link_data == link_pkg::ABORT_CODE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= link_pkg::wait_req;
            ack_cnt    <= '0;
            abort_q    <= 1'b0;
            link_abort <= 1'b0;
        end else begin
            abort_q    <= abort_now;
            link_abort <= abort_now && !abort_q;   // once per abort
            if (abort_now) begin
                state   <= link_pkg::wait_req;
                ack_cnt <= '0;
            end else begin
                case (state)
                    link_pkg::wait_req: begin
                        if (request) begin
                            state   <= link_pkg::ack_window;
                            ack_cnt <= '0;
                        end
                    end
                    link_pkg::ack_window: begin
                        if (ack_cnt == link_pkg::ACK_LAST) begin
                            state <= link_pkg::wait_req;
                        end else begin
                            ack_cnt <= ack_cnt + link_pkg::ack_cnt_t'(1);
                        end
                    end
                    default: begin
                        state <= link_pkg::wait_req;
                    end
                endcase
            end
        end
    end

    // symbol is captured when the request is accepted
    always_ff @(posedge clk) begin
        if (state == link_pkg::wait_req && request) begin
            sym_data <= link_data;
        end
    end

    assign ack      = (state == link_pkg::ack_window);
    assign sym_done = ack && (ack_cnt == link_pkg::ACK_LAST);   // last window cycle

endmodule

// File: logic/link_pkg.sv
package link_pkg;

    // link timing and queue size
    localparam int ACK_LEN     = 10;   // ack window is ACK_LEN + 1 cycles
    localparam int QUEUE_DEPTH = 4;
    localparam int SYM_W       = 6;

    typedef logic [SYM_W-1:0] symbol_t;

    // message fields, in link order
    typedef logic [3:0] msg_type_t;
    typedef logic [4:0] block_x_t;
    typedef logic [2:0] block_y_t;
    typedef logic [5:0] card_t;
    typedef logic [2:0] sel_len_t;
    typedef logic       move_dir_t;

    localparam symbol_t ABORT_CODE = '1;   // all ones with request high

    localparam int MSG_W = $bits(msg_type_t) + $bits(block_x_t) + $bits(block_y_t)
                         + $bits(card_t) + $bits(sel_len_t) + $bits(move_dir_t);

    typedef logic [MSG_W-1:0] msg_word_t;   // {type, x, y, card, len, dir}

    localparam int ACK_CNT_W = $clog2(ACK_LEN + 1);
    typedef logic [ACK_CNT_W-1:0] ack_cnt_t;
    localparam ack_cnt_t ACK_LAST = ack_cnt_t'(ACK_LEN);

    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [QPTR_W:0]   qcount_t;
    localparam qcount_t Q_FULL = qcount_t'(QUEUE_DEPTH);

    typedef enum logic {
        wait_req,
        ack_window
    } hs_state_t;

    typedef enum logic [2:0] {
        get_type,
        get_x,
        get_y,
        get_card,
        get_len,
        get_dir,
        finish
    } asm_state_t;

endpackage
